/* flist.f */
+incdir+rtl
rtl/credit_link_pkg.sv
rtl/credit_counter.sv
rtl/flit_sender.sv
rtl/rx_fifo.sv
rtl/flit_consumer.sv
rtl/credit_link_top.sv
sim/credit_link_sva.sv
sim/tb_credit_link.sv

/* run_sim.sh */
#!/bin/sh
# Build the credit link testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_credit_link -o sim_credit_link

# Verdict comes from the log, not the exit status
./obj_dir/sim_credit_link > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Run reported failure"
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "Run ended without a verdict"
  exit 1
fi
echo "Run passed"

/* sim/tb_credit_link.sv */
// Credit link testbench checking random flits against a reference model and credit limits

`timescale 1ns/100ps

`include "credit_link_consts.svh"

module tb_credit_link;

  localparam int credit_w = $clog2(`CL_FIFO_DEPTH + 1);
  localparam int drive_delay = 2;
  // Random data path length in accepted flits
  localparam int n_random = 400;
  // Offer window per credit limit run long enough to hit the limit and stay there
  localparam int window_cycles = `CL_FIFO_DEPTH + 4;
  // Pop to credit return plus the count update
  localparam int ret_settle_cycles = 3;
  // Budget of about 3 cycles per random flit plus 4 limit runs, reset and reinit
  localparam int test_cycles = n_random * 3 + 4 * 40 + 140;
  localparam int timeout_cycles = 2 * test_cycles;

  logic                   clk;
  logic                   reset;
  logic                   in_valid;
  credit_link_pkg::flit_t in_flit;
  logic                   in_ready;
  logic                   drain_en;
  logic [credit_w-1:0]    withhold;
  logic                   reinit;
  logic                   out_valid;
  logic [`CL_DATA_W-1:0]  out_result;
  logic [credit_w-1:0]    credit_value;
  logic [credit_w-1:0]    credit_available;

  // Reference model state
  credit_link_pkg::flit_t expect_q [$];
  logic [`CL_DATA_W-1:0]  model_acc = '0;
  int                     accept_count = 0;
  int                     result_count = 0;
  int                     cycle_count;
  string                  test_name = "reset";

  credit_link_top DUT (
    .clk              (clk),
    .reset            (reset),
    .in_valid         (in_valid),
    .in_flit          (in_flit),
    .in_ready         (in_ready),
    .drain_en         (drain_en),
    .withhold         (withhold),
    .reinit           (reinit),
    .out_valid        (out_valid),
    .out_result       (out_result),
    .credit_value     (credit_value),
    .credit_available (credit_available)
  );

  // ---------------------------------------------------------------------------
  // Clock and timeout
  // ---------------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: no verdict after %0d clock cycles", timeout_cycles);
    abort_run();
  end

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      abort_run();
    end
  endtask

  // Inputs change a little after the edge
  task automatic wait_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  // Mostly adds with some loads
  function automatic credit_link_pkg::flit_t random_flit();
    credit_link_pkg::flit_t f;
    f.op = (($urandom % 4) == 0) ? credit_link_pkg::OP_LOAD : credit_link_pkg::OP_ADD;
    f.payload = `CL_DATA_W'($urandom);
    return f;
  endfunction

  // Load takes the payload and add wraps at 2^16
  function automatic logic [`CL_DATA_W-1:0] next_acc(input logic [`CL_DATA_W-1:0] acc,
                                                     input credit_link_pkg::flit_t f);
    if (f.op == credit_link_pkg::OP_LOAD) begin
      return f.payload;
    end else begin
      return acc + f.payload;
    end
  endfunction

  // ---------------------------------------------------------------------------
  // Monitor sampled mid-cycle where everything is settled
  // ---------------------------------------------------------------------------

  always @(negedge clk) begin
    if (!reset) begin
      // Handshake seen here completes at the next edge
      if (in_valid && in_ready) begin
        expect_q.push_back(in_flit);
        accept_count++;
      end
      if (out_valid) begin
        if (expect_q.size() == 0) begin
          $display("Result strobe seen with no accepted flit outstanding");
          abort_run();
        end else begin
          model_acc = next_acc(model_acc, expect_q.pop_front());
          result_count++;
          check_value(test_name, int'(model_acc), int'(out_result));
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Test sequences
  // ---------------------------------------------------------------------------

  // Empty the FIFO and expect the pool whole again
  task automatic drain_and_recover();
    in_valid = 1'b0;
    drain_en = 1'b1;
    while (result_count < accept_count) begin
      wait_cycle();
    end
    repeat (ret_settle_cycles) wait_cycle();
    check_value({test_name, "_recovered"}, `CL_FIFO_DEPTH, int'(credit_value));
  endtask

  task automatic data_path_run();
    int base;
    int seen;
    test_name = "data_path";
    withhold = '0;
    base = accept_count;
    seen = accept_count;
    while (accept_count - base < n_random) begin
      // Offer held until taken
      if (!in_valid || accept_count != seen) begin
        seen = accept_count;
        in_valid = ($urandom % 4) != 0;
        in_flit = random_flit();
      end
      drain_en = ($urandom % 4) != 0;
      wait_cycle();
    end
    drain_and_recover();
  endtask

  // Drain off so only the pool limits acceptance
  task automatic credit_limit_run(input int w);
    int base;
    int seen;
    int taken;
    int exp_avail;
    test_name = $sformatf("withhold_%0d", w);
    base = accept_count;
    seen = accept_count;
    drain_en = 1'b0;
    withhold = credit_w'(w);
    in_valid = 1'b1;
    in_flit = random_flit();
    repeat (window_cycles) begin
      wait_cycle();
      if (accept_count != seen) begin
        seen = accept_count;
        in_flit = random_flit();
      end
      taken = accept_count - base;
      exp_avail = (`CL_FIFO_DEPTH - taken > w) ? `CL_FIFO_DEPTH - taken - w : 0;
      check_value({test_name, "_value"}, `CL_FIFO_DEPTH - taken, int'(credit_value));
      check_value({test_name, "_available"}, exp_avail, int'(credit_available));
    end
    in_valid = 1'b0;
    withhold = '0;
    check_value({test_name, "_accepted"}, (w < `CL_FIFO_DEPTH) ? `CL_FIFO_DEPTH - w : 0,
                accept_count - base);
    drain_and_recover();
  endtask

  // Link is idle here so reinit is legal
  task automatic reinit_check();
    int base;
    test_name = "reinit";
    base = accept_count;
    drain_en = 1'b0;
    reinit = 1'b1;
    in_valid = 1'b1;
    in_flit = random_flit();
    #1;
    check_value("reinit_ready", 0, int'(in_ready));
    wait_cycle();
    reinit = 1'b0;
    in_valid = 1'b0;
    check_value("reinit_value", `CL_FIFO_DEPTH, int'(credit_value));
    check_value("reinit_accepted", 0, accept_count - base);
  endtask

  initial begin
    void'($urandom(6328));
    reset = 1'b1;
    in_valid = 1'b0;
    in_flit = '0;
    drain_en = 1'b0;
    withhold = '0;
    reinit = 1'b0;
    repeat (4) @(posedge clk);
    #drive_delay;
    reset = 1'b0;
    data_path_run();
    credit_limit_run(0);
    credit_limit_run(3);
    credit_limit_run(6);
    credit_limit_run(`CL_FIFO_DEPTH);
    reinit_check();
    check_value("leftover_flits", 0, expect_q.size());
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* sim/credit_link_sva.sv */
// Bound checks on FIFO occupancy and credit pool invariants of the credit link

`timescale 1ns/100ps

module credit_link_sva #(
  // FIFO entries and credit pool size
  parameter int depth = 8,
  localparam int cnt_w = $clog2(depth + 1)
) (
  input logic             clk,
  input logic             reset,
  // Receive FIFO side
  input logic             wr_valid,
  input logic             pop,
  input logic             empty,
  input logic [cnt_w-1:0] count,
  // Credit counter side
  input logic [cnt_w-1:0] value,
  input logic             reinit,
  input logic             incr_valid
);

  // ---------------------------------------------------------------------------
  // FIFO invariants
  // ---------------------------------------------------------------------------

  // Credits must stop the link before the FIFO fills past depth
  a_no_overrun: assert property (@(posedge clk) disable iff (reset)
    (count == cnt_w'(depth)) |-> !wr_valid)
    else $error("FIFO written while holding %0d entries", depth);

  // Consumer only pops a non-empty FIFO
  a_no_underrun: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
    else $error("FIFO popped while empty");

  // ---------------------------------------------------------------------------
  // Credit invariants
  // ---------------------------------------------------------------------------

  // Pool never grows past the buffer it guards
  a_value_bound: assert property (@(posedge clk) disable iff (reset)
    value <= cnt_w'(depth))
    else $error("Credit count %0d above pool size %0d", value, depth);

  // Reload only while idle with the whole pool home and no return in flight
  a_reinit_idle: assert property (@(posedge clk) disable iff (reset)
    reinit |-> (value == cnt_w'(depth)) && !incr_valid)
    else $error("Reinit while credits are outstanding");

endmodule

// FIFO instance with the counter ports tied off
bind rx_fifo credit_link_sva #(.depth(depth)) u_fifo_sva (
  .clk(clk), .reset(reset), .wr_valid(wr_valid), .pop(pop), .empty(empty),
  .count(count), .value('0), .reinit(1'b0), .incr_valid(1'b0)
);

// Counter instance with the FIFO ports tied off
bind credit_counter credit_link_sva #(.depth(max_value)) u_counter_sva (
  .clk(clk), .reset(reset), .wr_valid(1'b0), .pop(1'b0), .empty(1'b1),
  .count('0), .value(value), .reinit(reinit), .incr_valid(incr_valid)
);

/* rtl/credit_link_top.sv */
// Credit link top wiring sender, credit counter, receive FIFO and consumer on one clock

`timescale 1ns/100ps

`include "credit_link_consts.svh"

module credit_link_top #(
  localparam int credit_w = $clog2(`CL_FIFO_DEPTH + 1)
) (
  input  logic                   clk,
  input  logic                   reset,
  // Input handshake
  input  logic                   in_valid,
  input  credit_link_pkg::flit_t in_flit,
  output logic                   in_ready,
  // Consumer control
  input  logic                   drain_en,
  // Credit control
  input  logic [credit_w-1:0]    withhold,
  input  logic                   reinit,
  // Results
  output logic                   out_valid,
  output logic [`CL_DATA_W-1:0]  out_result,
  // Credit observation
  output logic [credit_w-1:0]    credit_value,
  output logic [credit_w-1:0]    credit_available
);

  logic                         decr_valid;
  logic                         link_valid;
  credit_link_pkg::flit_t       link_flit;
  credit_link_pkg::flit_t       head_flit;
  logic                         fifo_empty;
  logic                         pop;
  credit_link_pkg::credit_ret_t credit_ret;

  // ---------------------------------------------------------------------------
  // Sender side
  // ---------------------------------------------------------------------------

  flit_sender u_sender (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_flit    (in_flit),
    .credit_ok  (in_ready),
    .decr_valid (decr_valid),
    .link_valid (link_valid),
    .link_flit  (link_flit)
  );

  // Sender spends one credit per flit
  credit_counter #(
    .max_value  (`CL_FIFO_DEPTH),
    .max_change (`CL_MAX_CHANGE)
  ) u_counter (
    .clk        (clk),
    .reset      (reset),
    .incr_valid (credit_ret.valid),
    .incr       (credit_ret.count),
    .decr_valid (decr_valid),
    .decr       (2'd1),
    .decr_ready (in_ready),
    .reinit     (reinit),
    .withhold   (withhold),
    .value      (credit_value),
    .available  (credit_available)
  );

  // ---------------------------------------------------------------------------
  // Receiver side
  // ---------------------------------------------------------------------------

  // Occupancy port left open and watched by the bound checks
  rx_fifo #(
    .depth (`CL_FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .reset     (reset),
    .wr_valid  (link_valid),
    .wr_flit   (link_flit),
    .pop       (pop),
    .head_flit (head_flit),
    .empty     (fifo_empty),
    .count     ()
  );

  flit_consumer u_consumer (
    .clk        (clk),
    .reset      (reset),
    .drain_en   (drain_en),
    .head_flit  (head_flit),
    .empty      (fifo_empty),
    .pop        (pop),
    .out_valid  (out_valid),
    .out_result (out_result),
    .credit_ret (credit_ret)
  );

endmodule

/* rtl/flit_consumer.sv */
// Flit consumer that drains the FIFO, runs opcodes on an accumulator and returns credits

`timescale 1ns/100ps

`include "credit_link_consts.svh"

module flit_consumer (
  input  logic                        clk,
  input  logic                        reset,
  // Drain permission from outside
  input  logic                        drain_en,
  // FIFO head
  input  credit_link_pkg::flit_t      head_flit,
  input  logic                        empty,
  output logic                        pop,
  // Result strobe one cycle after the pop
  output logic                        out_valid,
  output logic [`CL_DATA_W-1:0]       out_result,
  // Credit batch back to the counter
  output credit_link_pkg::credit_ret_t credit_ret
);

  logic [`CL_DATA_W-1:0]       acc;
  credit_link_pkg::cons_state_e state;
  credit_link_pkg::cons_state_e state_next;
  credit_link_pkg::credit_ret_t ret_next;

  // ---------------------------------------------------------------------------
  // Pop and execute
  // ---------------------------------------------------------------------------

  // Pop whenever allowed and something is there
  assign pop = drain_en && !empty;

  // Opcode decode on the popped head
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (pop) begin
      case (head_flit.op)
        credit_link_pkg::OP_LOAD: acc <= head_flit.payload;
        credit_link_pkg::OP_ADD:  acc <= acc + head_flit.payload;
        default:                  acc <= acc;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop;
    end
  end

  // Accumulator already updated when out_valid is high
  assign out_result = acc;

  // ---------------------------------------------------------------------------
  // Credit coalescing FSM
  // ---------------------------------------------------------------------------

  always_comb begin
    state_next     = state;
    ret_next.valid = 1'b0;
    ret_next.count = 2'd1;
    case (state)
      credit_link_pkg::CR_IDLE: begin
        // First credit waits for a partner
        if (pop) begin
          state_next = credit_link_pkg::CR_HOLD;
        end
      end
      credit_link_pkg::CR_HOLD: begin
        // Pair with this pop or send the lone credit
        ret_next.valid = 1'b1;
        ret_next.count = pop ? 2'd2 : 2'd1;
        state_next     = credit_link_pkg::CR_IDLE;
      end
      default: begin
        state_next = credit_link_pkg::CR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= credit_link_pkg::CR_IDLE;
      credit_ret <= '0;
    end else begin
      state      <= state_next;
      credit_ret <= ret_next;  // strobe lands one cycle later
    end
  end

endmodule

/* rtl/rx_fifo.sv */
// Receive FIFO as a circular flit buffer whose occupancy is bounded by the credit pool

`timescale 1ns/100ps

module rx_fifo #(
  // Entries equal to the initial credit pool
  parameter int depth = 8,
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1,
  localparam int count_w = $clog2(depth + 1)
) (
  input  logic                   clk,
  input  logic                   reset,
  // Write strobe from the link
  input  logic                   wr_valid,
  input  credit_link_pkg::flit_t wr_flit,
  // Head advance from the consumer
  input  logic                   pop,
  output credit_link_pkg::flit_t head_flit,
  output logic                   empty,
  output logic [count_w-1:0]     count
);

  credit_link_pkg::flit_t mem [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;

  // Next slot with wrap at depth
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ---------------------------------------------------------------------------
  // Storage
  // ---------------------------------------------------------------------------

  // Credits keep writes within depth
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_flit;
    end
  end

  // Head visible without a read strobe
  assign head_flit = mem[rd_ptr];

  // ---------------------------------------------------------------------------
  // Pointers and occupancy
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Write and pop together leave the count as is
      case ({wr_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign empty = (count == '0);

endmodule

/* rtl/flit_sender.sv */
// Flit sender accepting input flits against credit and driving them onto the link

`timescale 1ns/100ps

module flit_sender (
  input  logic                   clk,
  input  logic                   reset,
  // Input handshake with ready from the counter
  input  logic                   in_valid,
  input  credit_link_pkg::flit_t in_flit,
  input  logic                   credit_ok,
  // One-credit spend request
  output logic                   decr_valid,
  // Strobed link toward the receive FIFO
  output logic                   link_valid,
  output credit_link_pkg::flit_t link_flit
);

  logic accept;

  // ---------------------------------------------------------------------------
  // Credit request
  // ---------------------------------------------------------------------------

  // Every offered flit asks for one credit
  assign decr_valid = in_valid;

  // Transfer happens only with a grant
  assign accept = in_valid && credit_ok;

  // ---------------------------------------------------------------------------
  // Link register
  // ---------------------------------------------------------------------------

  // Strobe one cycle after acceptance
  always_ff @(posedge clk) begin
    if (reset) begin
      link_valid <= 1'b0;
    end else begin
      link_valid <= accept;
    end
  end

  // Payload held until the next accepted flit
  always_ff @(posedge clk) begin
    if (accept) begin
      link_flit <= in_flit;
    end
  end

endmodule

/* rtl/credit_counter.sv */
// Credit counter keeping the credit pool with increment, gated decrement, withhold and reinit

`timescale 1ns/100ps

`include "credit_link_consts.svh"

module credit_counter #(
  // Largest credit count held
  parameter int max_value = `CL_FIFO_DEPTH,
  // Largest change in one cycle in either direction
  parameter int max_change = `CL_MAX_CHANGE,
  localparam int value_w = $clog2(max_value + 1),
  localparam int change_w = $clog2(max_change + 1)
) (
  input  logic                clk,
  input  logic                reset,
  // Credits coming back from the receiver
  input  logic                incr_valid,
  input  logic [change_w-1:0] incr,
  // Credits spent by the sender
  input  logic                decr_valid,
  input  logic [change_w-1:0] decr,
  output logic                decr_ready,
  // Reload to the initial count while idle
  input  logic                reinit,
  // Credits kept out of circulation
  input  logic [value_w-1:0]  withhold,
  // Stored count without increment or withhold
  output logic [value_w-1:0]  value,
  // Spendable credit this cycle
  output logic [value_w-1:0]  available
);

  // Initial pool fills the receive FIFO exactly
  localparam logic [value_w-1:0] init_value = value_w'(`CL_FIFO_DEPTH);

  logic [value_w-1:0] incr_eff;
  logic [value_w-1:0] decr_eff;
  logic [value_w-1:0] value_plus_incr;

  // ---------------------------------------------------------------------------
  // Change terms
  // ---------------------------------------------------------------------------

  // Increments dropped during reinit
  assign incr_eff = (incr_valid && !reinit) ? value_w'(incr) : '0;

  // Only a granted decrement counts
  assign decr_eff = (decr_valid && decr_ready) ? value_w'(decr) : '0;

  assign value_plus_incr = value + incr_eff;

  // ---------------------------------------------------------------------------
  // Available credit and grant
  // ---------------------------------------------------------------------------

  // Incoming credit is usable at once and the withhold result floors at zero
  // Decrement left out here to keep ready free of a loop
  assign available = (value_plus_incr > withhold) ? value_plus_incr - withhold : '0;

  // Grant only when the request fits
  assign decr_ready = !reinit && (value_w'(decr) <= available);

  // ---------------------------------------------------------------------------
  // Count register
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      value <= init_value;
    end else if (reinit) begin
      value <= init_value;
    end else begin
      // Increment and decrement land in the same cycle
      value <= value_plus_incr - decr_eff;
    end
  end

endmodule

/* rtl/credit_link_pkg.sv */
// Credit link types for the flit opcode, flit format, credit return and consumer states

`include "credit_link_consts.svh"

package credit_link_pkg;

  // -------------------------------------------------------------------------
  // Flit format
  // -------------------------------------------------------------------------

  // Opcode carried with every flit
  typedef enum logic [0:0] {
    OP_LOAD = 1'b0,  // accumulator takes the payload
    OP_ADD  = 1'b1   // payload added modulo 2^16
  } flit_op_e;

  // One flit on the link with the opcode in the top bit
  typedef struct packed {
    flit_op_e              op;
    logic [`CL_DATA_W-1:0] payload;
  } flit_t;

  // -------------------------------------------------------------------------
  // Credit return
  // -------------------------------------------------------------------------

  // Credit batch strobe from consumer to counter
  typedef struct packed {
    logic                                valid;
    logic [$clog2(`CL_MAX_CHANGE+1)-1:0] count;
  } credit_ret_t;

  // Consumer coalescing states
  typedef enum logic [0:0] {
    CR_IDLE = 1'b0,  // nothing owed
    CR_HOLD = 1'b1   // one credit owed and waiting for a partner
  } cons_state_e;

endpackage

/* rtl/credit_link_consts.svh */
// Credit link constants for payload width, receive buffer depth and credit batch size

`ifndef CREDIT_LINK_CONSTS_SVH
`define CREDIT_LINK_CONSTS_SVH

// ---------------------------------------------------------------------------
// Data path
// ---------------------------------------------------------------------------

// Flit payload and accumulator width
`define CL_DATA_W 16

// ---------------------------------------------------------------------------
// Flow control
// ---------------------------------------------------------------------------

// Receive FIFO entries and also the initial and largest credit count
`define CL_FIFO_DEPTH 8

// Largest credit change in one cycle
`define CL_MAX_CHANGE 2

`endif
